/* tb.f */
src/enc_types_pkg.sv
src/enc_bus_pkg.sv
src/enc_quad_decoder.sv
src/enc_edge_period.sv
src/enc_period_select.sv
src/enc_wb_regs.sv
src/enc_velocity_top.sv
verif/enc_velocity_tb.sv

/* Makefile */
# Verilator build for the encoder speed testbench

TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = enc_velocity_tb
FILELIST = tb.f
BIN      = obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# pass only when the pass line shows up in the output
run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir

/* verif/enc_velocity_tb.sv */
// ------------------------------------------------
// testbench for enc_velocity_top with COUNT_WIDTH 12
// so a saturated count reads 4095
// encoder steps keep a fixed spacing of n cycles
// within one move, n is drawn from 40 to 200
// bus requests are held through the ack cycle
// ------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module enc_velocity_tb;

   localparam int          COUNT_WIDTH = 12;
   localparam logic [21:0] OVERFLOW    = 22'd4095;   // all ones in 12 bits

   logic clk_fast;
   logic reset;
   logic a;
   logic b;
   enc_bus_pkg::wb_req_t wb_req;
   enc_bus_pkg::wb_rsp_t wb_rsp;

   // reference model state
   logic [1:0]         enc_state;    // {b,a} as driven
   logic signed [15:0] model_pos;
   logic               model_dir;
   logic [1:0]         model_last;   // latest edge id
   int                 cycle = 0;
   int                 errors;
   int                 checks;

   enc_velocity_top #(.COUNT_WIDTH(COUNT_WIDTH)) uut (
      .clk_fast, .reset, .a, .b, .wb_req, .wb_rsp
   );

   initial begin
      clk_fast = 1'b0;
      forever #4 clk_fast = ~clk_fast;   // 8 ns period
   end

   always @(posedge clk_fast) cycle <= cycle + 1;

   // ------------------------------------------------
   // reference model
   // ------------------------------------------------
   // forward {b,a} order is 00 01 11 10, reverse runs it backwards
   function automatic logic [1:0] step_ref(input logic [1:0] s, input logic d);
      step_ref = ((s[0] == s[1]) ^ d) ? {s[1], ~s[0]} : {~s[1], s[0]};
   endfunction

   // edge id of a single line change, a_up 0 a_dn 1 b_up 2 b_dn 3
   function automatic logic [1:0] edge_ref(input logic [1:0] from, input logic [1:0] to);
      if (from[0] != to[0])
         edge_ref = to[0] ? 2'd0 : 2'd1;
      else
         edge_ref = to[1] ? 2'd2 : 2'd3;
   endfunction

   // dir 0 cycle a_up b_up a_dn b_dn
   function automatic logic [1:0] next_edge_ref(input logic [1:0] last, input logic d);
      case (last)
         2'd0:    next_edge_ref = d ? 2'd3 : 2'd2;
         2'd2:    next_edge_ref = d ? 2'd0 : 2'd1;
         2'd1:    next_edge_ref = d ? 2'd2 : 2'd3;
         default: next_edge_ref = d ? 2'd1 : 2'd0;
      endcase
   endfunction

   // expected period word, msb first
   function automatic logic [31:0] period_ref(input logic latched, input logic d,
                                              input logic chg, input logic [1:0] id,
                                              input logic [21:0] cnt);
      period_ref = {latched, d, chg, id, 5'd0, cnt};
   endfunction

   // ------------------------------------------------
   // helpers
   // ------------------------------------------------
   task automatic tick;
      @(posedge clk_fast);
      #1;   // inputs move 1 ns after the edge
   endtask

   task automatic idle(input int n);
      repeat (n) tick();
   endtask

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERR %0t ns %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic wb_cycle(input logic we, input logic [3:0] adr, input logic [31:0] wdat,
                           output logic [31:0] rdat);
      int   waited;
      logic got_ack;
      waited       = 0;
      got_ack      = 1'b0;
      rdat         = '0;
      wb_req.cyc   = 1'b1;
      wb_req.stb   = 1'b1;
      wb_req.we    = we;
      wb_req.adr   = adr;
      wb_req.dat_w = wdat;
      while (!got_ack && waited < 20) begin   // ack timeout
         tick();
         waited++;
         if (wb_rsp.ack) begin
            got_ack = 1'b1;
            rdat    = wb_rsp.dat_r;
         end
      end
      if (!got_ack) begin
         errors++;
         $display("register slave gave no ack within 20 cycles at address %0d", adr);
      end else begin
         tick();   // request stays up through the ack cycle
      end
      wb_req = '0;
   endtask

   task automatic wb_read(input logic [3:0] adr, output logic [31:0] rdat);
      wb_cycle(1'b0, adr, 32'd0, rdat);
   endtask

   task automatic wb_write(input logic [3:0] adr, input logic [31:0] wdat);
      logic [31:0] unused;
      wb_cycle(1'b1, adr, wdat, unused);
   endtask

   task automatic check_position;
      logic [31:0] rd;
      wb_read(enc_bus_pkg::reg_position, rd);
      check("position", rd, {{16{model_pos[15]}}, model_pos});   // sign extended
   endtask

   task automatic check_status(input logic err);
      logic [31:0] rd;
      wb_read(enc_bus_pkg::reg_status, rd);
      check("status", rd, {30'd0, err, model_dir});
   endtask

   // steps at n cycle spacing, period read 10 cycles after each checked step
   task automatic move(input int steps, input logic d, input int n);
      logic [1:0]  nxt;
      logic [31:0] rd;
      logic        reversal;
      int          start;
      for (int i = 0; i < steps; i++) begin
         start      = cycle;
         reversal   = (d != model_dir);
         nxt        = step_ref(enc_state, d);
         model_last = edge_ref(enc_state, nxt);
         enc_state  = nxt;
         {b, a}     = nxt;
         model_dir  = d;
         model_pos  = d ? model_pos - 16'sd1 : model_pos + 16'sd1;
         if (reversal || i >= 4) begin
            idle(9);
            wb_read(enc_bus_pkg::reg_period, rd);
            if (reversal)   // other counters forced to overflow
               check("period", rd, period_ref(1'b0, d, 1'b1,
                                              next_edge_ref(model_last, d), OVERFLOW));
            else            // same kind edges are 4 steps apart
               check("period", rd, period_ref(1'b1, d, 1'b0, model_last, 22'(4 * n - 1)));
         end
         while (cycle < start + n)
            tick();
      end
   endtask

   // ------------------------------------------------
   // test sequence
   // ------------------------------------------------
   initial begin
      logic [31:0] rd;
      logic [1:0]  nxt_id;
      int          n;
      int          steps;
      reset      = 1'b0;
      a          = 1'b0;
      b          = 1'b0;
      wb_req     = '0;
      enc_state  = 2'b00;
      model_pos  = '0;
      model_dir  = 1'b0;
      model_last = 2'd0;
      errors     = 0;
      checks     = 0;
      n          = 40;
      void'($urandom(32'hd9623249));
      repeat (3) @(posedge clk_fast);
      #1 reset = 1'b1;
      idle(2);

      // everything reads zero after reset
      wb_read(enc_bus_pkg::reg_position, rd);
      check("position", rd, 32'd0);
      wb_read(enc_bus_pkg::reg_period, rd);
      check("period", rd, 32'd0);
      wb_read(enc_bus_pkg::reg_status, rd);
      check("status", rd, 32'd0);
      wb_read(4'd9, rd);
      check("unmapped read data", rd, 32'd0);

      // alternating moves, each after the first starts with a reversal
      for (int m = 0; m < 6; m++) begin
         n     = int'($urandom_range(200, 40));
         steps = int'($urandom_range(16, 8));
         move(steps, logic'(m % 2), n);
         check_position();
         check_status(1'b0);
      end

      // preload, then move on from it
      wb_write(enc_bus_pkg::reg_position, 32'h0000_fed4);
      model_pos = -16'sd300;
      n         = int'($urandom_range(200, 40));
      steps     = int'($urandom_range(16, 8));
      move(steps, 1'b0, n);
      check_position();

      // standstill, the pending edge takes over
      idle(8 * n + 8);
      nxt_id = next_edge_ref(model_last, model_dir);
      wb_read(enc_bus_pkg::reg_period, rd);
      check("period is_latched", 32'(rd[31]), 32'd0);
      check("period dir", 32'(rd[30]), 32'(model_dir));
      check("period edge id", 32'(rd[28:27]), 32'(nxt_id));
      checks++;
      if (rd[21:0] <= 22'(4 * n - 1)) begin
         errors++;
         $display("period count %0d after standstill is not above %0d", rd[21:0], 4 * n - 1);
      end
      idle(4200);
      wb_read(enc_bus_pkg::reg_period, rd);
      check("period", rd, period_ref(1'b0, model_dir, 1'b0, nxt_id, OVERFLOW));

      // both lines at once is illegal
      enc_state = ~enc_state;
      {b, a}    = enc_state;
      idle(10);
      check_position();
      check_status(1'b1);
      wb_write(enc_bus_pkg::reg_status, 32'h0000_0002);
      check_status(1'b0);

      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

`default_nettype wire

/* src/enc_velocity_top.sv */
// ------------------------------------------------
// encoder speed measurement with a wishbone slave
// everything runs on clk_fast, a and b may be
// asynchronous to it
// a pin edge shows in a period read within 5 cycles
// ------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module enc_velocity_top #(
   parameter int COUNT_WIDTH = 22   // 8 to 22
) (
   input  wire                       clk_fast,
   input  wire                       reset,    // async, active low
   input  wire                       a,
   input  wire                       b,
   input  wire enc_bus_pkg::wb_req_t wb_req,
   output enc_bus_pkg::wb_rsp_t      wb_rsp
);

   enc_types_pkg::edge_strobe_t edges;
   enc_types_pkg::position_t    position;
   enc_types_pkg::position_t    preload_value;
   enc_types_pkg::edge_meas_t   a_up_meas, a_dn_meas, b_up_meas, b_dn_meas;
   enc_types_pkg::period_word_t period;
   logic dir, quad_error, preload, error_clear;

   enc_quad_decoder u_decoder (
      .clk_fast, .reset, .a, .b, .preload, .preload_value, .error_clear,
      .edges, .dir, .position, .quad_error
   );

   // one counter per edge kind
   enc_edge_period #(.COUNT_WIDTH(COUNT_WIDTH)) u_a_up (
      .clk_fast, .reset, .strobe(edges.a_up), .dir, .meas(a_up_meas));
   enc_edge_period #(.COUNT_WIDTH(COUNT_WIDTH)) u_a_dn (
      .clk_fast, .reset, .strobe(edges.a_dn), .dir, .meas(a_dn_meas));
   enc_edge_period #(.COUNT_WIDTH(COUNT_WIDTH)) u_b_up (
      .clk_fast, .reset, .strobe(edges.b_up), .dir, .meas(b_up_meas));
   enc_edge_period #(.COUNT_WIDTH(COUNT_WIDTH)) u_b_dn (
      .clk_fast, .reset, .strobe(edges.b_dn), .dir, .meas(b_dn_meas));

   enc_period_select #(.COUNT_WIDTH(COUNT_WIDTH)) u_select (
      .clk_fast, .reset, .edges, .dir,
      .a_up_meas, .a_dn_meas, .b_up_meas, .b_dn_meas, .period
   );

   enc_wb_regs u_regs (
      .clk_fast, .reset, .wb_req, .position, .period, .dir, .quad_error,
      .wb_rsp, .preload, .preload_value, .error_clear
   );

endmodule

`default_nettype wire

/* src/enc_wb_regs.sv */
// ------------------------------------------------
// wishbone classic register slave
// ack one cycle after cyc and stb are first seen
// master must hold its request until ack
// writes to read only or unmapped words are acked
// and dropped, unmapped reads give zero
// ------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module enc_wb_regs (
   input  wire                         clk_fast,
   input  wire                         reset,       // async, active low
   input  wire enc_bus_pkg::wb_req_t   wb_req,
   input  wire enc_types_pkg::position_t position,
   input  wire enc_types_pkg::period_word_t period,
   input  wire                         dir,
   input  wire                         quad_error,
   output enc_bus_pkg::wb_rsp_t        wb_rsp,
   output logic                        preload,     // one cycle
   output enc_types_pkg::position_t    preload_value,
   output logic                        error_clear  // one cycle
);

   logic                  take;    // request seen and not yet acked
   logic                  ack;     // one cycle pulse
   enc_bus_pkg::wb_data_t dat_r;   // read data, valid with ack

   assign take   = wb_req.cyc & wb_req.stb & ~ack;
   assign wb_rsp = {ack, dat_r};

   // ------------------------------------------------
   // ack and write strobes
   // ------------------------------------------------
   always_ff @(posedge clk_fast or negedge reset) begin
      if (!reset) begin
         ack         <= 1'b0;
         preload     <= 1'b0;
         error_clear <= 1'b0;
      end else begin
         ack         <= take;
         preload     <= take & wb_req.we & (wb_req.adr == enc_bus_pkg::reg_position);
         error_clear <= take & wb_req.we & (wb_req.adr == enc_bus_pkg::reg_status)
                        & wb_req.dat_w[enc_bus_pkg::status_err_bit];
      end
   end

   // ------------------------------------------------
   // read data and preload value
   // ------------------------------------------------
   always_ff @(posedge clk_fast) begin
      if (take) begin
         preload_value <= enc_types_pkg::position_t'(wb_req.dat_w[15:0]);
         case (wb_req.adr)
            enc_bus_pkg::reg_position:
               dat_r <= {{16{position[15]}}, position};  // sign extended
            enc_bus_pkg::reg_period:
               dat_r <= period;
            enc_bus_pkg::reg_status: begin
               dat_r <= '0;
               dat_r[enc_bus_pkg::status_dir_bit] <= dir;
               dat_r[enc_bus_pkg::status_err_bit] <= quad_error;
            end
            default:
               dat_r <= '0;
         endcase
      end
   end

   // master keeps its request up for the whole ack cycle
   a_ack_in_cycle: assert property (@(posedge clk_fast) disable iff (!reset)
      ack |-> (wb_req.cyc && wb_req.stb))
      else $error("ack outside an active bus cycle");

endmodule

`default_nettype wire

/* src/enc_period_select.sv */
// ------------------------------------------------
// picks the reported period word from the four
// edge measurements
// reports the larger of the latest edge's latched
// count and the next expected edge's running count
// word stays zero until the first edge after reset
// output lags its inputs by one cycle
// ------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module enc_period_select #(
   parameter int COUNT_WIDTH = 22
) (
   input  wire                         clk_fast,
   input  wire                         reset,    // async, active low
   input  wire enc_types_pkg::edge_strobe_t edges,
   input  wire                         dir,
   input  wire enc_types_pkg::edge_meas_t  a_up_meas,
   input  wire enc_types_pkg::edge_meas_t  a_dn_meas,
   input  wire enc_types_pkg::edge_meas_t  b_up_meas,
   input  wire enc_types_pkg::edge_meas_t  b_dn_meas,
   output enc_types_pkg::period_word_t     period
);

   localparam enc_types_pkg::count_t OVERFLOW =
      enc_types_pkg::count_t'({COUNT_WIDTH{1'b1}});

   enc_types_pkg::edge_meas_t meas_arr [4];   // indexed by edge id
   enc_types_pkg::edge_id_t   last_id;        // most recent strobed edge
   enc_types_pkg::edge_id_t   next_id;        // edge expected next
   enc_types_pkg::edge_meas_t last_meas;
   enc_types_pkg::edge_meas_t next_meas;
   logic                      seen;           // any edge since reset

   assign meas_arr[enc_types_pkg::a_up] = a_up_meas;
   assign meas_arr[enc_types_pkg::a_dn] = a_dn_meas;
   assign meas_arr[enc_types_pkg::b_up] = b_up_meas;
   assign meas_arr[enc_types_pkg::b_dn] = b_dn_meas;

   // dir 0 cycle is a_up b_up a_dn b_dn, dir 1 runs it backwards
   always_comb begin
      case (last_id)
         enc_types_pkg::a_up: next_id = dir ? enc_types_pkg::b_dn : enc_types_pkg::b_up;
         enc_types_pkg::b_up: next_id = dir ? enc_types_pkg::a_up : enc_types_pkg::a_dn;
         enc_types_pkg::a_dn: next_id = dir ? enc_types_pkg::b_up : enc_types_pkg::b_dn;
         default:             next_id = dir ? enc_types_pkg::a_dn : enc_types_pkg::a_up;
      endcase
      last_meas = meas_arr[last_id];
      next_meas = meas_arr[next_id];
   end

   // ------------------------------------------------
   // latest edge tracking
   // ------------------------------------------------
   always_ff @(posedge clk_fast or negedge reset) begin
      if (!reset) begin
         last_id <= enc_types_pkg::a_up;
         seen    <= 1'b0;
      end else begin
         if (edges != '0)
            seen <= 1'b1;
         // fixed priority, two strobes only come with a decode error
         if (edges.a_up)      last_id <= enc_types_pkg::a_up;
         else if (edges.b_up) last_id <= enc_types_pkg::b_up;
         else if (edges.a_dn) last_id <= enc_types_pkg::a_dn;
         else if (edges.b_dn) last_id <= enc_types_pkg::b_dn;
      end
   end

   // ------------------------------------------------
   // period word
   // ------------------------------------------------
   always_ff @(posedge clk_fast or negedge reset) begin
      if (!reset) begin
         period <= '0;
      end else if (seen) begin
         period.dir <= dir;
         period.pad <= '0;
         if (next_meas.running >= last_meas.latched) begin
            // slow or stopped, the pending edge is already late
            period.is_latched  <= 1'b0;
            period.dir_changed <= next_meas.dir_changed;
            period.edge_id     <= next_id;
            period.count       <= next_meas.running;
         end else begin
            period.is_latched  <= 1'b1;
            period.dir_changed <= last_meas.dir_changed;
            period.edge_id     <= last_id;
            period.count       <= last_meas.latched;
         end
      end
   end

   // counters feeding this block never report past overflow
   a_count_range: assert property (@(posedge clk_fast) disable iff (!reset)
      period.count <= OVERFLOW)
      else $error("period count above overflow");

endmodule

`default_nettype wire

/* src/enc_edge_period.sv */
// ------------------------------------------------
// period counter for one edge kind
// counts clk_fast cycles between two strobes and
// saturates at all ones in COUNT_WIDTH bits
// a direction change forces the count to overflow
// until the next strobe of this kind
// ------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module enc_edge_period #(
   parameter int COUNT_WIDTH = 22   // 8 to 22
) (
   input  wire                       clk_fast,
   input  wire                       reset,    // async, active low
   input  wire                       strobe,   // this edge kind, one cycle
   input  wire                       dir,
   output enc_types_pkg::edge_meas_t meas
);

   localparam enc_types_pkg::count_t OVERFLOW =
      enc_types_pkg::count_t'({COUNT_WIDTH{1'b1}});

   logic dir_r;   // dir one cycle back

   always_ff @(posedge clk_fast or negedge reset) begin
      if (!reset) begin
         dir_r            <= 1'b0;
         meas.latched     <= '0;
         meas.running     <= '0;
         meas.dir_changed <= 1'b0;
      end else begin
         dir_r <= dir;
         if (strobe) begin
            // latched ends up as edge spacing minus one
            meas.latched     <= meas.running;
            meas.running     <= '0;
            meas.dir_changed <= 1'b0;
         end else if (dir != dir_r) begin
            meas.running     <= OVERFLOW;   // reads as standstill
            meas.dir_changed <= 1'b1;
         end else if (meas.running != OVERFLOW) begin
            meas.running <= meas.running + enc_types_pkg::count_t'(1);
         end
      end
   end

   // saturation holds even across strobes and reversals
   a_running_max: assert property (@(posedge clk_fast) disable iff (!reset)
      meas.running <= OVERFLOW)
      else $error("running count above overflow");

endmodule

`default_nettype wire

/* src/enc_quad_decoder.sv */
// ------------------------------------------------
// quadrature decoder for asynchronous a and b lines
// two flop synchronizer, then compare with the
// previous state, so outputs lag the pins by 3 cycles
// no glitch filter, a pin held at 1 through reset
// gives one step right after reset
// ------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module enc_quad_decoder (
   input  wire                       clk_fast,
   input  wire                       reset,          // async, active low
   input  wire                       a,
   input  wire                       b,
   input  wire                       preload,        // one cycle strobe
   input  wire enc_types_pkg::position_t preload_value,
   input  wire                       error_clear,    // one cycle strobe
   output enc_types_pkg::edge_strobe_t edges,
   output logic                      dir,            // 0 when a leads b
   output enc_types_pkg::position_t  position,
   output logic                      quad_error      // sticky
);

   logic [1:0] a_sync;   // [1] is the synchronized copy
   logic [1:0] b_sync;
   enc_types_pkg::quad_state_t cur_state;
   enc_types_pkg::quad_state_t prev_state;
   logic a_chg, b_chg;
   logic jump;        // both lines moved at once
   logic step_fwd;    // single step in the a-leads-b order

   // next state when moving forward
   function automatic enc_types_pkg::quad_state_t fwd_next(
      input enc_types_pkg::quad_state_t s);
      case (s)
         enc_types_pkg::quad_00: fwd_next = enc_types_pkg::quad_01;  // a rises
         enc_types_pkg::quad_01: fwd_next = enc_types_pkg::quad_11;  // b rises
         enc_types_pkg::quad_11: fwd_next = enc_types_pkg::quad_10;  // a falls
         default:                fwd_next = enc_types_pkg::quad_00;  // b falls
      endcase
   endfunction

   always_comb begin
      cur_state = enc_types_pkg::quad_state_t'({b_sync[1], a_sync[1]});
      a_chg     = a_sync[1] ^ prev_state[0];
      b_chg     = b_sync[1] ^ prev_state[1];
      jump      = a_chg & b_chg;
      step_fwd  = (fwd_next(prev_state) == cur_state);
   end

   always_ff @(posedge clk_fast or negedge reset) begin
      if (!reset) begin
         a_sync     <= 2'b00;
         b_sync     <= 2'b00;
         prev_state <= enc_types_pkg::quad_00;
         edges      <= '0;
         dir        <= 1'b0;
         position   <= '0;
         quad_error <= 1'b0;
      end else begin
         a_sync     <= {a_sync[0], a};
         b_sync     <= {b_sync[0], b};
         prev_state <= cur_state;

         // one strobe per line that moved, both on a jump
         edges.a_up <= a_chg &  a_sync[1];
         edges.a_dn <= a_chg & ~a_sync[1];
         edges.b_up <= b_chg &  b_sync[1];
         edges.b_dn <= b_chg & ~b_sync[1];

         if (preload) begin
            position <= preload_value;   // preload wins over a step
         end else if ((a_chg ^ b_chg) && step_fwd) begin
            position <= position + 16'sd1;
         end else if (a_chg ^ b_chg) begin
            position <= position - 16'sd1;
         end

         if (a_chg ^ b_chg)
            dir <= ~step_fwd;

         if (jump)
            quad_error <= 1'b1;          // set beats clear
         else if (error_clear)
            quad_error <= 1'b0;
      end
   end

   // two strobes in one cycle only come from an illegal jump
   a_single_strobe: assert property (@(posedge clk_fast) disable iff (!reset)
      !$onehot0(edges) |-> quad_error)
      else $error("several edge strobes without quad_error");

endmodule

`default_nettype wire

/* src/enc_bus_pkg.sv */
// ------------------------------------------------
// wishbone classic bus types and register map
// word addressed, 32 bit data, no burst and no
// err or rty signals
// ------------------------------------------------
`default_nettype none

package enc_bus_pkg;

   typedef logic [3:0]  wb_addr_t;   // word address
   typedef logic [31:0] wb_data_t;

   // master to slave, held until ack
   typedef struct packed {
      logic     cyc;
      logic     stb;
      logic     we;
      wb_addr_t adr;
      wb_data_t dat_w;
   } wb_req_t;

   // slave to master
   typedef struct packed {
      logic     ack;    // one cycle pulse
      wb_data_t dat_r;  // valid with ack only
   } wb_rsp_t;

   // ------------------------------------------------
   // register map
   // ------------------------------------------------
   localparam wb_addr_t reg_position = 4'd0;  // read, write preloads
   localparam wb_addr_t reg_period   = 4'd1;  // read only
   localparam wb_addr_t reg_status   = 4'd2;  // read, write 1 to bit1 clears error

   localparam int status_dir_bit = 0;
   localparam int status_err_bit = 1;

endpackage

`default_nettype wire

/* src/enc_types_pkg.sv */
// ------------------------------------------------
// encoder side types shared by the decoder, the
// edge period counters and the period selector
// count_t is sized for the widest count, the active
// width is set per instance by COUNT_WIDTH (8 to 22)
// ------------------------------------------------
`default_nettype none

package enc_types_pkg;

   // ------------------------------------------------
   // widths with a meaning
   // ------------------------------------------------
   typedef logic [21:0]        count_t;     // clk_fast cycles between edges
   typedef logic signed [15:0] position_t;  // quarter steps, wraps silently
   typedef logic [1:0]         edge_id_t;   // which of the four edge kinds

   localparam edge_id_t a_up = 2'd0;
   localparam edge_id_t a_dn = 2'd1;
   localparam edge_id_t b_up = 2'd2;
   localparam edge_id_t b_dn = 2'd3;

   // one cycle strobes from the decoder
   typedef struct packed {
      logic a_up;
      logic a_dn;
      logic b_up;
      logic b_dn;
   } edge_strobe_t;

   // per edge kind measurement, 45 bits
   typedef struct packed {
      count_t latched;      // spacing of the last two edges minus one
      count_t running;      // cycles since the last edge, saturating
      logic   dir_changed;  // direction flipped since the last edge
   } edge_meas_t;

   // reported period word, 32 bits, msb first
   typedef struct packed {
      logic       is_latched;   // 1 when count is a latched spacing
      logic       dir;
      logic       dir_changed;
      edge_id_t   edge_id;
      logic [4:0] pad;          // always zero
      count_t     count;
   } period_word_t;

   // gray states of {b,a}, forward order 00 01 11 10
   typedef enum logic [1:0] {
      quad_00 = 2'b00,
      quad_01 = 2'b01,
      quad_11 = 2'b11,
      quad_10 = 2'b10
   } quad_state_t;

endpackage

`default_nettype wire
